// ==== common/zx_bus_pkg.sv ====
`default_nettype none

package zx_bus_pkg;

	// z80 address and data bus
	typedef logic [15:0] zaddr_t;
	typedef logic [7:0]  zdata_t;

	////////////////////////////////////////////////////////////////////////////
	// i/o port addresses
	////////////////////////////////////////////////////////////////////////////

	// memory paging port, full decode
	parameter zaddr_t PORT_7FFD = 16'h7FFD;
	// extended mode port, full decode
	parameter zaddr_t PORT_EFF7 = 16'hEFF7;

	// low byte only decodes
	parameter zdata_t PORT_FE_LOW = 8'hFE;
	// window page port, a[15:14] picks the window
	parameter zdata_t PORT_F7_LOW = 8'hF7;

	// high address bytes seen by the dos flag logic
	parameter zdata_t DOS_ENTRY_HIGH = 8'h3D;
	parameter zdata_t RAM_START_HIGH = 8'h40;

endpackage

`default_nettype wire

// ==== common/zx_mem_pkg.sv ====
`default_nettype none

package zx_mem_pkg;

	// 64 pages of 16k give a 1M physical space
	typedef logic [5:0]  page_t;
	typedef logic [19:0] phys_addr_t;

	// 16k windows in the z80 space
	parameter int N_WINDOWS = 4;

	////////////////////////////////////////////////////////////////////////////
	// window mapping after reset
	////////////////////////////////////////////////////////////////////////////

	// window 0 is rom, the rest ram
	parameter bit WIN_RESET_ROM [N_WINDOWS] = '{1'b1, 1'b0, 1'b0, 1'b0};

	// pentagon-like layout: rom 0, ram 5, ram 2, ram from 7ffd
	parameter page_t WIN_RESET_PAGE [N_WINDOWS] = '{6'd0, 6'd5, 6'd2, 6'd0};

	// windows 1 and 2 take their page as stored
	parameter bit WIN_RESET_ATM [N_WINDOWS] = '{1'b0, 1'b1, 1'b1, 1'b0};

	////////////////////////////////////////////////////////////////////////////
	// z80 clock
	////////////////////////////////////////////////////////////////////////////

	// fclk cycles per z80 clock
	parameter int ZCLK_DIV_NORMAL = 8;
	parameter int ZCLK_DIV_TURBO  = 4;

endpackage

`default_nettype wire

// ==== logic/pentevo_core.sv ====
`default_nettype none

module pentevo_core
(
	input  logic                   fclk,
	input  logic                   reset,
	input  zx_bus_pkg::zaddr_t     a,
	input  zx_bus_pkg::zdata_t     d,
	input  logic                   iorq_n,
	input  logic                   mreq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	input  logic                   m1_n,
	output logic                   clkz_out,
	output zx_mem_pkg::phys_addr_t mem_addr,
	output logic                   csrom,
	output logic                   dos,
	output logic [2:0]             border,
	output logic                   beep
);

	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	logic                 zpos;
	logic                 turbo_n;
	logic                 basic_rom;
	zdata_t               p7ffd;
	logic [N_WINDOWS-1:0] pager_wr;
	page_t                win_page [N_WINDOWS];
	logic [N_WINDOWS-1:0] win_romnram;
	logic [N_WINDOWS-1:0] win_atm;

	// falling strobe is not needed by this core
	zclock u_zclock (.fclk(fclk), .reset(reset), .turbo_n(turbo_n),
		.clkz_out(clkz_out), .zpos(zpos), .zneg());

	zports u_zports (.fclk(fclk), .reset(reset), .zpos(zpos), .a(a), .d(d),
		.iorq_n(iorq_n), .wr_n(wr_n), .m1_n(m1_n), .pager_wr(pager_wr),
		.p7ffd(p7ffd), .turbo_n(turbo_n), .border(border), .beep(beep));

	////////////////////////////////////////////////////////////////////////////
	// window pagers
	////////////////////////////////////////////////////////////////////////////

	for (genvar w = 0; w < N_WINDOWS; w++)
	begin : g_pager
		atm_pager #(.WINDOW(w), .RESET_ROM(WIN_RESET_ROM[w]),
			.RESET_PAGE(WIN_RESET_PAGE[w]), .RESET_ATM(WIN_RESET_ATM[w])) u_pager (
			.fclk(fclk), .reset(reset), .wr(pager_wr[w]), .d(d),
			.page(win_page[w]), .romnram(win_romnram[w]), .atm_mode(win_atm[w]));
	end

	zdos u_zdos (.fclk(fclk), .reset(reset), .zpos(zpos), .m1_n(m1_n),
		.mreq_n(mreq_n), .rd_n(rd_n), .a_high(a[15:8]), .basic_rom(basic_rom), .dos(dos));

	zmem_map u_zmem_map (.a(a), .mreq_n(mreq_n),
		.win0_page(win_page[0]), .win0_romnram(win_romnram[0]), .win0_atm_mode(win_atm[0]),
		.win1_page(win_page[1]), .win1_romnram(win_romnram[1]), .win1_atm_mode(win_atm[1]),
		.win2_page(win_page[2]), .win2_romnram(win_romnram[2]), .win2_atm_mode(win_atm[2]),
		.win3_page(win_page[3]), .win3_romnram(win_romnram[3]), .win3_atm_mode(win_atm[3]),
		.p7ffd(p7ffd), .dos(dos), .mem_addr(mem_addr), .csrom(csrom), .basic_rom(basic_rom));

endmodule

`default_nettype wire

// ==== logic/zclock.sv ====
`default_nettype none

module zclock
(
	input  logic fclk,
	input  logic reset,
	input  logic turbo_n,
	output logic clkz_out,
	output logic zpos,
	output logic zneg
);

	import zx_mem_pkg::*;

	localparam int CNT_W = $clog2(ZCLK_DIV_NORMAL);

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_half;
	logic [CNT_W-1:0] cnt_last;
	// divisor in use, only changes at the falling edge
	logic             turbo_q;

	assign cnt_half = turbo_q ? CNT_W'(ZCLK_DIV_TURBO / 2 - 1) : CNT_W'(ZCLK_DIV_NORMAL / 2 - 1);
	assign cnt_last = turbo_q ? CNT_W'(ZCLK_DIV_TURBO - 1) : CNT_W'(ZCLK_DIV_NORMAL - 1);

	// low phase first, rise at half count, fall at wrap
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			cnt      <= '0;
			turbo_q  <= 1'b0;
			clkz_out <= 1'b0;
			zpos     <= 1'b0;
			zneg     <= 1'b0;
		end
		else
		begin
			zpos <= 1'b0;
			zneg <= 1'b0;
			if (cnt == cnt_last)
			begin
				cnt      <= '0;
				clkz_out <= 1'b0;
				zneg     <= 1'b1;
				// new rate starts with the coming low phase
				turbo_q  <= ~turbo_n;
			end
			else
			begin
				cnt <= cnt + 1'b1;
				if (cnt == cnt_half)
				begin
					clkz_out <= 1'b1;
					zpos     <= 1'b1;
				end
			end
		end
	end

	// strobes are exclusive and alternate
	a_strobe_excl: assert property (@(posedge fclk) disable iff (reset) !(zpos && zneg));
	a_strobe_alt: assert property (@(posedge fclk) disable iff (reset)
		zpos |=> (!zpos throughout zneg[->1]));

endmodule

`default_nettype wire

// ==== paging/atm_pager.sv ====
`default_nettype none

module atm_pager
#(
	parameter int                WINDOW     = 0,
	parameter bit                RESET_ROM  = 1'b0,
	parameter zx_mem_pkg::page_t RESET_PAGE = '0,
	parameter bit                RESET_ATM  = 1'b0
)
(
	input  logic               fclk,
	input  logic               reset,
	input  logic               wr,
	input  zx_bus_pkg::zdata_t d,
	output zx_mem_pkg::page_t  page,
	output logic               romnram,
	output logic               atm_mode
);

	import zx_mem_pkg::*;

	if (WINDOW >= N_WINDOWS)
	begin : g_bad_window
		$error("atm_pager window %0d out of range", WINDOW);
	end

	// port data is stored inverted, as on the ATM
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			page     <= RESET_PAGE;
			romnram  <= RESET_ROM;
			atm_mode <= RESET_ATM;
		end
		else if (wr)
		begin
			atm_mode <= d[7];
			romnram  <= ~d[6];
			page     <= ~d[5:0];
		end
	end

	// reset mapping stays until the first write to this window
	a_reset_hold: assert property (@(posedge fclk)
		$fell(reset) |-> (page == RESET_PAGE) until wr)
		else $error("window %0d lost its reset page", WINDOW);

endmodule

`default_nettype wire

// ==== paging/zdos.sv ====
`default_nettype none

module zdos
(
	input  logic       fclk,
	input  logic       reset,
	input  logic       zpos,
	input  logic       m1_n,
	input  logic       mreq_n,
	input  logic       rd_n,
	input  logic [7:0] a_high,
	input  logic       basic_rom,
	output logic       dos
);

	import zx_bus_pkg::*;

	logic fetch;

	// opcode fetch, sampled once per z80 clock
	assign fetch = zpos & ~m1_n & ~mreq_n & ~rd_n;

	always_ff @(posedge fclk)
	begin
		if (reset)
			dos <= 1'b0;
		else if (fetch)
		begin
			// leaving rom space ends TR-DOS
			if (a_high >= RAM_START_HIGH)
				dos <= 1'b0;
			else if (a_high == DOS_ENTRY_HIGH && basic_rom)
				dos <= 1'b1;
		end
	end

	a_no_rise_in_ram: assert property (@(posedge fclk) disable iff (reset)
		(fetch && a_high >= RAM_START_HIGH) |=> !dos);

endmodule

`default_nettype wire

// ==== paging/zmem_map.sv ====
`default_nettype none

module zmem_map
(
	input  zx_bus_pkg::zaddr_t     a,
	input  logic                   mreq_n,
	input  zx_mem_pkg::page_t      win0_page,
	input  logic                   win0_romnram,
	input  logic                   win0_atm_mode,
	input  zx_mem_pkg::page_t      win1_page,
	input  logic                   win1_romnram,
	input  logic                   win1_atm_mode,
	input  zx_mem_pkg::page_t      win2_page,
	input  logic                   win2_romnram,
	input  logic                   win2_atm_mode,
	input  zx_mem_pkg::page_t      win3_page,
	input  logic                   win3_romnram,
	input  logic                   win3_atm_mode,
	input  zx_bus_pkg::zdata_t     p7ffd,
	input  logic                   dos,
	output zx_mem_pkg::phys_addr_t mem_addr,
	output logic                   csrom,
	output logic                   basic_rom
);

	import zx_mem_pkg::*;

	page_t sel_page;
	page_t eff_page;
	logic  sel_rom;
	logic  sel_atm;

	// window select by the top two address bits
	always_comb
	begin
		case (a[15:14])
			2'd0:    {sel_page, sel_rom, sel_atm} = {win0_page, win0_romnram, win0_atm_mode};
			2'd1:    {sel_page, sel_rom, sel_atm} = {win1_page, win1_romnram, win1_atm_mode};
			2'd2:    {sel_page, sel_rom, sel_atm} = {win2_page, win2_romnram, win2_atm_mode};
			default: {sel_page, sel_rom, sel_atm} = {win3_page, win3_romnram, win3_atm_mode};
		endcase
	end

	// pentagon rules mix in 7ffd, atm mode takes the page as is
	always_comb
	begin
		if (sel_atm)
			eff_page = sel_page;
		else if (sel_rom)
			eff_page = {sel_page[5:1], p7ffd[4] & ~dos};
		else
			eff_page = {sel_page[5:3], p7ffd[2:0]};
	end

	assign mem_addr  = {eff_page, a[13:0]};
	assign csrom     = ~mreq_n & sel_rom;
	// basic 48 rom paged in, used for TR-DOS entry
	assign basic_rom = win0_romnram & ~win0_atm_mode & p7ffd[4];

endmodule

`default_nettype wire

// ==== pentevo_core.f ====
common/zx_bus_pkg.sv
common/zx_mem_pkg.sv
logic/zclock.sv
ports/zports.sv
paging/atm_pager.sv
paging/zdos.sv
paging/zmem_map.sv
logic/pentevo_core.sv
test/tb_pentevo_core.sv

// ==== ports/zports.sv ====
`default_nettype none

module zports
(
	input  logic                            fclk,
	input  logic                            reset,
	input  logic                            zpos,
	input  zx_bus_pkg::zaddr_t              a,
	input  zx_bus_pkg::zdata_t              d,
	input  logic                            iorq_n,
	input  logic                            wr_n,
	input  logic                            m1_n,
	output logic [zx_mem_pkg::N_WINDOWS-1:0] pager_wr,
	output zx_bus_pkg::zdata_t              p7ffd,
	output logic                            turbo_n,
	output logic [2:0]                      border,
	output logic                            beep
);

	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	zdata_t               peff7;
	logic                 io_wr;
	logic                 wr_stb;
	logic                 f7_hit;
	logic [N_WINDOWS-1:0] win_sel;

	// m1 high keeps interrupt acknowledge out
	assign io_wr  = ~iorq_n & ~wr_n & m1_n;
	assign wr_stb = zpos & io_wr;

	// EFF7 shares the F7 low byte but is the mode port, not a window
	assign f7_hit = (a[7:0] == PORT_F7_LOW) && (a != PORT_EFF7);

	always_comb
	begin
		win_sel = '0;
		if (wr_stb && f7_hit)
			win_sel[a[15:14]] = 1'b1;
	end

	// pulse lines up with the zpos cycle
	assign pager_wr = win_sel;

	////////////////////////////////////////////////////////////////////////////
	// port registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			p7ffd  <= '0;
			peff7  <= 8'h10;
			border <= '0;
			beep   <= 1'b0;
		end
		else if (wr_stb)
		begin
			if (a == PORT_7FFD)
				p7ffd <= d;
			if (a == PORT_EFF7)
				peff7 <= d;
			if (a[7:0] == PORT_FE_LOW)
			begin
				border <= d[2:0];
				beep   <= d[4];
			end
		end
	end

	// bit 4 set means normal speed
	assign turbo_n = peff7[4];

	a_pager_onehot: assert property (@(posedge fclk) disable iff (reset)
		$onehot0(pager_wr));

endmodule

`default_nettype wire

// ==== test/pentevo_input.txt ====
# op name addr data exp1 exp2, all numbers in hex
# R: mem_addr csrom, F: dos, B: border beep, T: fclk per clkz_out, W: none
T clk_normal 0000 00 8 0
R reset_rom 0000 00 00000 1
R reset_win1 4123 00 14123 0
R reset_win2 8456 00 08456 0
W p7ffd_ram 7FFD 03 0 0
R p7ffd_ram_rd C010 00 0C010 0
W p7ffd_rom 7FFD 13 0 0
R p7ffd_rom_rd 0000 00 04000 1
F dos_entry 3D2F 00 1 0
R dos_rom_even 0000 00 00000 1
F dos_exit 8000 00 0 0
W rom_select_off 7FFD 03 0 0
F dos_no_entry 3D2F 00 0 0
W win1_port 40F7 B6 0 0
R win1_rom 4000 00 24000 1
W win0_port 00F7 B9 0 0
W p7ffd_back 7FFD 13 0 0
R win0_atm 0000 00 18000 1
W win3_port C0F7 77 0 0
R win3_pentagon C005 00 2C005 0
W port_fe 00FE 15 0 0
B fe_border 0000 00 5 1
W eff7_turbo EFF7 00 0 0
T clk_turbo 0000 00 4 0

// ==== test/tb_pentevo_core.sv ====
`default_nettype none

module tb_pentevo_core;

	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	localparam int HOLD_CYCLES  = 20;
	localparam int IDLE_CYCLES  = 4;
	localparam int RESET_CYCLES = 16;
	localparam int EDGE_TIMEOUT = 64;

	logic       fclk;
	logic       reset;
	zaddr_t     a;
	zdata_t     d;
	logic       iorq_n;
	logic       mreq_n;
	logic       rd_n;
	logic       wr_n;
	logic       m1_n;
	logic       clkz_out;
	phys_addr_t mem_addr;
	logic       csrom;
	logic       dos;
	logic [2:0] border;
	logic       beep;
	int         err_count;
	int         timeout_count;

	pentevo_core uut (.fclk(fclk), .reset(reset), .a(a), .d(d), .iorq_n(iorq_n),
		.mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n), .clkz_out(clkz_out),
		.mem_addr(mem_addr), .csrom(csrom), .dos(dos), .border(border), .beep(beep));

	initial
	begin
		fclk = 1'b0;
		forever #2 fclk = ~fclk;
	end

	////////////////////////////////////////////////////////////////////////////
	// bus tasks, all start and end on a falling edge
	////////////////////////////////////////////////////////////////////////////

	task automatic idle_bus;
		a      = '0;
		d      = '0;
		iorq_n = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge fclk);
	endtask

	task automatic check_value(input logic [8*24-1:0] name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("FAILED %0s: expected %0h, actual %0h", name, expected, actual);
			err_count++;
		end
	endtask

	task automatic io_write(input zaddr_t addr, input zdata_t data);
		a      = addr;
		d      = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		wait_cycles(HOLD_CYCLES);
		idle_bus();
		wait_cycles(IDLE_CYCLES);
	endtask

	// map is combinational, so sample while the bus is still held
	task automatic mem_read(input logic [8*24-1:0] name, input zaddr_t addr,
		input logic [31:0] exp_addr, input logic [31:0] exp_csrom);
		a      = addr;
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		wait_cycles(HOLD_CYCLES);
		check_value(name, exp_addr, 32'(mem_addr));
		check_value(name, exp_csrom, 32'(csrom));
		idle_bus();
		wait_cycles(IDLE_CYCLES);
	endtask

	task automatic opcode_fetch(input logic [8*24-1:0] name, input zaddr_t addr,
		input logic [31:0] exp_dos);
		a      = addr;
		m1_n   = 1'b0;
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		wait_cycles(HOLD_CYCLES);
		idle_bus();
		wait_cycles(IDLE_CYCLES);
		check_value(name, exp_dos, 32'(dos));
	endtask

	// cycles counts falling edges up to the next seen clkz_out rise
	task automatic wait_clkz_rise(output int cycles);
		logic prev;
		logic rose;
		prev   = clkz_out;
		rose   = 1'b0;
		cycles = 0;
		while (!rose && cycles < EDGE_TIMEOUT)
		begin
			@(negedge fclk);
			cycles++;
			rose = clkz_out && !prev;
			prev = clkz_out;
		end
		if (!rose)
		begin
			$display("timeout: clkz_out did not rise within %0d fclk cycles", EDGE_TIMEOUT);
			timeout_count++;
		end
	endtask

	task automatic measure_period(input logic [8*24-1:0] name, input logic [31:0] expected);
		int cycles;
		// first rise, then two settling periods before the measured one
		wait_clkz_rise(cycles);
		wait_clkz_rise(cycles);
		wait_clkz_rise(cycles);
		wait_clkz_rise(cycles);
		check_value(name, expected, 32'(cycles));
	endtask

	task automatic run_record(input logic [7:0] op, input logic [8*24-1:0] name,
		input zaddr_t addr, input zdata_t data, input logic [31:0] exp1,
		input logic [31:0] exp2);
		case (op)
			"W": io_write(addr, data);
			"R": mem_read(name, addr, exp1, exp2);
			"F": opcode_fetch(name, addr, exp1);
			"B":
			begin
				check_value(name, exp1, 32'(border));
				check_value(name, exp2, 32'(beep));
			end
			"T": measure_period(name, exp1);
			default:
			begin
				$display("unknown operation %c in record %0s", op, name);
				err_count++;
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int                 fd;
		int                 n;
		int                 records;
		logic               done;
		logic [8*8-1:0]     op;
		logic [8*24-1:0]    name;
		logic [8*128-1:0]   skip_line;
		logic [15:0]        addr;
		logic [7:0]         data;
		logic [31:0]        exp1;
		logic [31:0]        exp2;

		err_count     = 0;
		timeout_count = 0;
		records       = 0;
		done          = 1'b0;
		reset         = 1'b1;
		idle_bus();
		wait_cycles(RESET_CYCLES);
		reset = 1'b0;
		wait_cycles(2);

		fd = $fopen("test/pentevo_input.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file test/pentevo_input.txt");
			err_count++;
			done = 1'b1;
		end
		while (!done)
		begin
			n = $fscanf(fd, "%s", op);
			if (n != 1)
				done = 1'b1;
			else if (op[7:0] == "#")
				n = $fgets(skip_line, fd);
			else
			begin
				n = $fscanf(fd, "%s %h %h %h %h", name, addr, data, exp1, exp2);
				if (n != 5)
				begin
					$display("malformed record after operation %0s in stimulus file", op);
					err_count++;
					done = 1'b1;
				end
				else
				begin
					run_record(op[7:0], name, addr, data, exp1, exp2);
					records++;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (records == 0)
		begin
			$display("no records were read from the stimulus file");
			err_count++;
		end

		$display("%0d records, %0d mismatches, %0d timeouts", records, err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
